/* logic/decode_macros.svh */
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// Opcodes in inst[15:12]
`define OP_ADD     4'h0
`define OP_SUB     4'h1
`define OP_XOR     4'h2
`define OP_RED     4'h3
`define OP_SLL     4'h4
`define OP_SRA     4'h5
`define OP_ROR     4'h6
`define OP_PADDSB  4'h7
`define OP_LW      4'h8
`define OP_SW      4'h9
`define OP_LLB     4'hA
`define OP_LHB     4'hB
`define OP_B       4'hC
`define OP_BR      4'hD
`define OP_PCS     4'hE
`define OP_HLT     4'hF

// Branch condition codes in inst[11:9]
`define CC_NE      3'd0
`define CC_EQ      3'd1
`define CC_GT      3'd2
`define CC_LT      3'd3
`define CC_GE      3'd4
`define CC_LE      3'd5
`define CC_OV      3'd6
`define CC_UN      3'd7

// Bit index of each flag in flagVec
`define FLAG_Z     2
`define FLAG_V     1
`define FLAG_N     0

// Low bit of each instruction field
`define OPC_LO     12      // Opcode, 4 bits
`define RD_LO      8       // Destination reg, 4 bits
`define RS_LO      4       // First source reg, 4 bits
`define RT_LO      0       // Second source reg or nibble immediate
`define CC_LO      9       // Condition code, 3 bits
`define BR_BIT     12      // Set for BR, clear for B
`define OFF_LO     0       // Branch offset, 9 bits

`endif

/* logic/decodePkg.sv */
`default_nettype none

package decodePkg;

  typedef logic [15:0] word;      // Data word or address
  typedef logic [3:0]  regId;     // Register number
  typedef logic [3:0]  opcodeT;   // inst[15:12]
  typedef logic [3:0]  aluOpT;    // ALU operation select
  typedef logic [2:0]  flagVec;   // {Z, V, N}
  typedef logic [2:0]  condCode;  // Branch condition

  // Execute stage bundle, 63 bits
  typedef struct packed {
    regId  srcReg1;
    regId  srcReg2;
    word   aluIn1;   // First register read
    word   aluImm;   // Extended immediate
    word   aluIn2;   // Second register read
    aluOpT aluOp;
    logic  aluSrc;   // Immediate as second operand
    logic  zEn;      // Z flag update
    logic  nvEn;     // N and V flag update
  } exSignals;

  // Memory stage bundle, 18 bits
  typedef struct packed {
    word  memWriteData;
    logic memEnable;
    logic memWrite;
  } memSignals;

  // Write-back stage bundle, 8 bits
  typedef struct packed {
    regId regRd;
    logic regWrite;
    logic memToReg;
    logic hlt;
    logic pcs;
  } wbSignals;

  // Register write from write-back, 21 bits
  typedef struct packed {
    logic wen;
    regId rd;
    word  data;
  } regWriteReq;

  // Branch resolution and predictor update, 22 bits
  typedef struct packed {
    logic isBranch;
    logic isBr;
    word  target;
    logic actualTaken;  // Only valid with isBranch
    logic wenBtb;
    logic wenBht;
    logic updatePc;     // Redirect fetch on mispredict
  } branchUpdate;

endpackage

`default_nettype wire

/* logic/registerFile.sv */
`timescale 1ns/1ps
`default_nettype none

module registerFile
  import decodePkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  regId       rdAddr1,  // Read port 1 address
  input  regId       rdAddr2,  // Read port 2 address
  input  regWriteReq wrReq,    // Write port from write-back
  output word        rdData1,
  output word        rdData2
);

  word  regs [16];   // Register array
  logic hit1, hit2;  // Same-cycle write to a read address

  //////////////////////////////
  // Write port
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;  // Clear whole file
      end
    end else if (wrReq.wen && (wrReq.rd != '0)) begin
      regs[wrReq.rd] <= wrReq.data;  // R0 stays read-only
    end
  end

  //////////////////////////////
  // Read ports with bypass
  //////////////////////////////
  assign hit1 = wrReq.wen && (wrReq.rd == rdAddr1);
  assign hit2 = wrReq.wen && (wrReq.rd == rdAddr2);

  // R0 is hardwired zero, else newest data wins
  assign rdData1 = (rdAddr1 == '0) ? '0 : (hit1 ? wrReq.data : regs[rdAddr1]);
  assign rdData2 = (rdAddr2 == '0) ? '0 : (hit2 ? wrReq.data : regs[rdAddr2]);

endmodule

`default_nettype wire

/* logic/controlUnit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "decode_macros.svh"

module controlUnit
  import decodePkg::*;
(
  input  opcodeT opcode,
  input  logic   condMet,          // Resolved branch direction
  input  word    target,           // Resolved branch target
  input  logic   predictedTaken,   // Fetch-stage prediction
  input  word    predictedTarget,
  output logic   isBranch,
  output logic   wenBtb,
  output logic   wenBht,
  output logic   updatePc,
  output aluOpT  aluOp,
  output logic   aluSrc,
  output logic   regSrc,           // Read rd as first source
  output logic   zEn,
  output logic   nvEn,
  output logic   memEnable,
  output logic   memWrite,
  output logic   regWrite,
  output logic   memToReg,
  output logic   hlt,
  output logic   pcs
);

  logic dirMiss;     // Wrong direction predicted
  logic targetMiss;  // Right direction, wrong address

  //////////////////////////////
  // Opcode decode
  //////////////////////////////
  always_comb begin
    aluOp     = `OP_ADD;  // Address and pass-through ops add
    aluSrc    = 1'b0;
    regSrc    = 1'b0;
    zEn       = 1'b0;
    nvEn      = 1'b0;
    memEnable = 1'b0;
    memWrite  = 1'b0;
    regWrite  = 1'b0;
    memToReg  = 1'b0;
    hlt       = 1'b0;
    pcs       = 1'b0;
    isBranch  = 1'b0;
    case (opcode)
      `OP_ADD, `OP_SUB: begin
        aluOp    = opcode;
        zEn      = 1'b1;
        nvEn     = 1'b1;  // Only arithmetic sets N and V
        regWrite = 1'b1;
      end
      `OP_XOR: begin
        aluOp    = opcode;
        zEn      = 1'b1;
        regWrite = 1'b1;
      end
      `OP_RED, `OP_PADDSB: begin
        aluOp    = opcode;  // No flag update
        regWrite = 1'b1;
      end
      `OP_SLL, `OP_SRA, `OP_ROR: begin
        aluOp    = opcode;
        aluSrc   = 1'b1;    // Shift amount from nibble
        zEn      = 1'b1;
        regWrite = 1'b1;
      end
      `OP_LW: begin
        aluSrc    = 1'b1;
        memEnable = 1'b1;
        regWrite  = 1'b1;
        memToReg  = 1'b1;
      end
      `OP_SW: begin
        aluSrc    = 1'b1;
        memEnable = 1'b1;
        memWrite  = 1'b1;   // Store data comes from rd
      end
      `OP_LLB, `OP_LHB: begin
        aluOp    = opcode;
        aluSrc   = 1'b1;
        regSrc   = 1'b1;    // Keep other byte of rd
        regWrite = 1'b1;
      end
      `OP_B, `OP_BR: isBranch = 1'b1;
      `OP_PCS: begin
        regWrite = 1'b1;
        pcs      = 1'b1;
      end
      `OP_HLT: hlt = 1'b1;
    endcase
  end

  //////////////////////////////
  // Predictor update
  //////////////////////////////
  assign dirMiss    = condMet ^ predictedTaken;
  assign targetMiss = condMet & predictedTaken & (predictedTarget != target);

  assign wenBht   = isBranch;            // History trains on every branch
  assign wenBtb   = isBranch & condMet;  // Targets only stored when taken
  assign updatePc = isBranch & (dirMiss | targetMiss);

endmodule

`default_nettype wire

/* logic/branchControl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "decode_macros.svh"

module branchControl
  import decodePkg::*;
(
  input  condCode    cond,
  input  logic [8:0] offset,   // Word offset from pcNext
  input  flagVec     flags,
  input  word        rsData,   // Register target for BR
  input  logic       isBr,
  input  word        pcNext,
  output logic       condMet,
  output word        target
);

  logic z, v, n;  // Individual flags
  word  pcRel;    // PC-relative target

  assign z = flags[`FLAG_Z];
  assign v = flags[`FLAG_V];
  assign n = flags[`FLAG_N];

  //////////////////////////////
  // Condition evaluation
  //////////////////////////////
  always_comb begin
    condMet = 1'b0;
    case (cond)
      `CC_NE: condMet = ~z;
      `CC_EQ: condMet = z;
      `CC_GT: condMet = ~z & ~n;
      `CC_LT: condMet = n;
      `CC_GE: condMet = z | (~z & ~n);  // Equal or greater
      `CC_LE: condMet = n | z;
      `CC_OV: condMet = v;
      `CC_UN: condMet = 1'b1;           // Unconditional
    endcase
  end

  //////////////////////////////
  // Target select
  //////////////////////////////
  // Offset counts halfwords, so shift left by one
  assign pcRel  = pcNext + {{6{offset[8]}}, offset, 1'b0};
  assign target = isBr ? rsData : pcRel;

endmodule

`default_nettype wire

/* logic/decodeStage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "decode_macros.svh"

module decodeStage
  import decodePkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  word         inst,             // Instruction from fetch
  input  word         pcNext,           // Address after inst
  input  flagVec      flags,
  input  logic        predictedTaken,
  input  word         predictedTarget,
  input  regWriteReq  wbReq,            // Register write from write-back
  output exSignals    exSig,
  output memSignals   memSig,
  output wbSignals    wbSig,
  output branchUpdate brUpd
);

  // Instruction fields
  opcodeT     opcode;
  regId       rd, rs, rt;
  condCode    cond;
  logic [8:0] offset;
  logic       isBr;

  // Control from opcode
  aluOpT aluOp;
  logic  aluSrc, regSrc, zEn, nvEn;
  logic  memEnable, memWrite, regWrite, memToReg, hlt, pcs;
  logic  isBranch, wenBtb, wenBht, updatePc;

  // Branch result
  logic condMet;
  word  target;

  // Operands
  regId srcReg1, srcReg2;
  word  rdData1, rdData2;
  word  immExt, aluImm;

  //////////////////////////////
  // Field extraction
  //////////////////////////////
  assign opcode = inst[`OPC_LO +: 4];
  assign rd     = inst[`RD_LO +: 4];
  assign rs     = inst[`RS_LO +: 4];
  assign rt     = inst[`RT_LO +: 4];  // Doubles as nibble immediate
  assign cond   = inst[`CC_LO +: 3];
  assign offset = inst[`OFF_LO +: 9];
  assign isBr   = inst[`BR_BIT];

  controlUnit iCtrl (.*);  // Ports share names with locals

  branchControl iBranch (
    .cond    (cond),
    .offset  (offset),
    .flags   (flags),
    .rsData  (rdData1),
    .isBr    (isBr),
    .pcNext  (pcNext),
    .condMet (condMet),
    .target  (target)
  );

  //////////////////////////////
  // Register read
  //////////////////////////////
  assign srcReg1 = regSrc ? rd : rs;    // LLB/LHB modify rd in place
  assign srcReg2 = memWrite ? rd : rt;  // SW stores rd

  registerFile iRegs (
    .clk     (clk),
    .rst     (rst),
    .rdAddr1 (srcReg1),
    .rdAddr2 (srcReg2),
    .wrReq   (wbReq),
    .rdData1 (rdData1),
    .rdData2 (rdData2)
  );

  // Memory offsets are signed, shift amounts are not
  assign immExt = memEnable ? {{12{rt[3]}}, rt} : {12'h000, rt};
  assign aluImm = regSrc ? {8'h00, rs, rt} : immExt;  // Low byte for LLB/LHB

  //////////////////////////////
  // Stage bundles
  //////////////////////////////
  always_comb begin
    exSig.srcReg1 = srcReg1;
    exSig.srcReg2 = srcReg2;
    exSig.aluIn1  = rdData1;
    exSig.aluImm  = aluImm;
    exSig.aluIn2  = rdData2;  // Execute picks reg or imm via aluSrc
    exSig.aluOp   = aluOp;
    exSig.aluSrc  = aluSrc;
    exSig.zEn     = zEn;
    exSig.nvEn    = nvEn;

    memSig.memWriteData = rdData2;
    memSig.memEnable    = memEnable;
    memSig.memWrite     = memWrite;

    wbSig.regRd    = rd;
    wbSig.regWrite = regWrite;
    wbSig.memToReg = memToReg;
    wbSig.hlt      = hlt;
    wbSig.pcs      = pcs;

    brUpd.isBranch    = isBranch;
    brUpd.isBr        = isBr;
    brUpd.target      = target;
    brUpd.actualTaken = condMet;
    brUpd.wenBtb      = wenBtb;
    brUpd.wenBht      = wenBht;
    brUpd.updatePc    = updatePc;
  end

endmodule

`default_nettype wire

/* dv/decodeStage_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeStageAsserts
  import decodePkg::*;
(
  input logic        clk,
  input logic        rst,
  input branchUpdate brUpd  // Predictor update from the stage
);

  //////////////////////////////
  // Predictor strobe rules
  //////////////////////////////
  btbNeedsBht: assert property (@(posedge clk) disable iff (rst)
    brUpd.wenBtb |-> brUpd.wenBht)
    else $error("wenBtb asserted without wenBht");

  redirectOnBranch: assert property (@(posedge clk) disable iff (rst)
    brUpd.updatePc |-> brUpd.isBranch)
    else $error("updatePc asserted on a non-branch");

  // Quiet predictor when not a branch
  quietOffBranch: assert property (@(posedge clk) disable iff (rst)
    !brUpd.isBranch |-> !(brUpd.wenBtb || brUpd.wenBht || brUpd.updatePc))
    else $error("Predictor strobe active without isBranch");

endmodule

bind decodeStage decodeStageAsserts branchChecks (.clk(clk), .rst(rst), .brUpd(brUpd));

`default_nettype wire

/* dv/decodeStage_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "decode_macros.svh"

module decodeStage_tb
  import decodePkg::*;
();

  logic        clk, rst;
  word         inst, pcNext, predictedTarget;
  flagVec      flags;
  logic        predictedTaken;
  regWriteReq  wbReq;
  exSignals    exSig;
  memSignals   memSig;
  wbSignals    wbSig;
  branchUpdate brUpd;

  word shadow [16];  // Reference copy of the register file
  int  errors = 0;
  int  checks = 0;

  decodeStage dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////
  // Checking and driving
  //////////////////////////////
  task automatic checkVal(input string name, input word got, input word exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("CHECK FAILED t=%0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    checkVal(name, word'(got), word'(exp));
  endtask

  // Sample at the falling edge once outputs are known
  task automatic settle();
    int waited;
    waited = 0;
    @(negedge clk);
    while ($isunknown({exSig, memSig, wbSig, brUpd}) && waited < 8) begin
      waited++;
      @(negedge clk);
    end
    if ($isunknown({exSig, memSig, wbSig, brUpd})) begin
      $display("Timeout: DUT outputs still unknown after %0d cycles", waited);
      $display("FAIL: see errors above");
      $finish;
    end
  endtask

  task automatic applyInst(input word i, input regWriteReq w);
    @(posedge clk);
    inst  <= i;
    wbReq <= w;  // Write-back request for this cycle only
    settle();
  endtask

  task automatic driveBranch(input word i, input word pc, input flagVec f,
                             input logic pTaken, input word pTarget);
    @(posedge clk);
    inst            <= i;
    pcNext          <= pc;
    flags           <= f;
    predictedTaken  <= pTaken;
    predictedTarget <= pTarget;
    wbReq           <= '0;
    settle();
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////
  function automatic logic condExpected(input condCode cc, input flagVec f);
    logic z, v, n;
    z = f[`FLAG_Z];
    v = f[`FLAG_V];
    n = f[`FLAG_N];
    case (cc)
      `CC_NE:  return !z;
      `CC_EQ:  return z;
      `CC_GT:  return !z && !n;
      `CC_LT:  return n;
      `CC_GE:  return z || !n;  // Not less than
      `CC_LE:  return n || z;
      `CC_OV:  return v;
      default: return 1'b1;
    endcase
  endfunction

  // Offset in halfwords, signed
  function automatic word relTarget(input word pc, input logic [8:0] off);
    int delta;
    delta = off[8] ? int'(off) - 512 : int'(off);
    return word'(int'(pc) + 2 * delta);
  endfunction

  //////////////////////////////
  // Directed tests
  //////////////////////////////
  task automatic testResetZero();
    for (int r = 0; r < 16; r++) begin
      applyInst({`OP_ADD, 4'h1, regId'(r), 4'h0}, '0);
      checkVal($sformatf("aluIn1 r%0d after reset", r), exSig.aluIn1, 16'h0000);
    end
  endtask

  task automatic testRegWrites();
    word d;
    for (int r = 1; r < 16; r++) begin
      d = word'($urandom);
      applyInst({`OP_ADD, 4'h1, regId'(r), regId'(r)}, '{1'b1, regId'(r), d});
      checkVal($sformatf("aluIn1 bypass r%0d", r), exSig.aluIn1, d);  // Same cycle
      checkVal($sformatf("aluIn2 bypass r%0d", r), exSig.aluIn2, d);
      shadow[r] = d;
    end
    applyInst({`OP_ADD, 4'h1, 4'h0, 4'h0}, '{1'b1, 4'h0, 16'hBEEF});
    checkVal("aluIn1 r0 during write", exSig.aluIn1, 16'h0000);
    for (int r = 1; r < 16; r++) begin
      applyInst({`OP_ADD, 4'h1, regId'(r), regId'(r % 15 + 1)}, '0);
      checkVal($sformatf("aluIn1 r%0d", r), exSig.aluIn1, shadow[r]);
      checkVal($sformatf("aluIn2 r%0d", r % 15 + 1), exSig.aluIn2, shadow[r % 15 + 1]);
    end
    applyInst({`OP_ADD, 4'h1, 4'h0, 4'h0}, '0);
    checkVal("aluIn1 r0 after write", exSig.aluIn1, 16'h0000);
  endtask

  task automatic testDecodeTable();
    word    i;
    opcodeT op;
    regId   rd, s1, s2;
    logic   rSrc, mWr, ldSt;
    string  tag;
    for (int k = 0; k < 16; k++) begin
      op = opcodeT'(k);
      i  = {op, 12'($urandom)};
      rd = i[11:8];
      applyInst(i, '0);
      tag  = $sformatf("op%0h ", k);
      rSrc = op inside {`OP_LLB, `OP_LHB};
      mWr  = (op == `OP_SW);
      ldSt = op inside {`OP_LW, `OP_SW};
      s1   = rSrc ? rd : i[7:4];  // rd for LLB and LHB
      s2   = mWr ? rd : i[3:0];   // rd for SW
      checkVal({tag, "aluOp"}, word'(exSig.aluOp), word'((k < 8 || rSrc) ? op : `OP_ADD));
      checkBit({tag, "aluSrc"}, exSig.aluSrc,
               op inside {`OP_SLL, `OP_SRA, `OP_ROR} || ldSt || rSrc);
      checkBit({tag, "zEn"}, exSig.zEn, op inside {`OP_ADD, `OP_SUB, `OP_XOR,
                                                   `OP_SLL, `OP_SRA, `OP_ROR});
      checkBit({tag, "nvEn"}, exSig.nvEn, op inside {`OP_ADD, `OP_SUB});
      checkBit({tag, "memEnable"}, memSig.memEnable, ldSt);
      checkBit({tag, "memWrite"}, memSig.memWrite, mWr);
      checkBit({tag, "regWrite"}, wbSig.regWrite,
               k < 8 || rSrc || op inside {`OP_LW, `OP_PCS});
      checkBit({tag, "memToReg"}, wbSig.memToReg, op == `OP_LW);
      checkBit({tag, "hlt"}, wbSig.hlt, op == `OP_HLT);
      checkBit({tag, "pcs"}, wbSig.pcs, op == `OP_PCS);
      checkBit({tag, "isBranch"}, brUpd.isBranch, op inside {`OP_B, `OP_BR});
      checkVal({tag, "srcReg1"}, word'(exSig.srcReg1), word'(s1));
      checkVal({tag, "srcReg2"}, word'(exSig.srcReg2), word'(s2));
      checkVal({tag, "regRd"}, word'(wbSig.regRd), word'(rd));
      checkVal({tag, "aluIn1"}, exSig.aluIn1, shadow[s1]);
      checkVal({tag, "aluIn2"}, exSig.aluIn2, shadow[s2]);
      checkVal({tag, "memWriteData"}, memSig.memWriteData, shadow[s2]);
    end
  endtask

  task automatic testImmediates();
    logic [3:0] nib;
    logic [7:0] lowByte;
    nib = {1'b1, 3'($urandom)};  // Negative nibble
    applyInst({`OP_LW, 8'($urandom), nib}, '0);
    checkVal("aluImm LW", exSig.aluImm, {12'hFFF, nib});
    applyInst({`OP_SLL, 8'($urandom), nib}, '0);
    checkVal("aluImm SLL", exSig.aluImm, {12'h000, nib});
    lowByte = 8'($urandom);
    applyInst({`OP_LHB, 4'($urandom), lowByte}, '0);
    checkVal("aluImm LHB", exSig.aluImm, {8'h00, lowByte});
  endtask

  task automatic testBranches();
    condCode    cc;
    logic [8:0] off;
    word        pc;
    flagVec     f;
    regId       r;
    for (int k = 0; k < 16; k++) begin
      cc  = condCode'($urandom);
      off = 9'($urandom);
      pc  = word'($urandom);
      f   = flagVec'($urandom);
      r   = regId'($urandom % 15 + 1);
      driveBranch({`OP_B, cc, off}, pc, f, 1'b0, 16'h0000);
      checkBit("B actualTaken", brUpd.actualTaken, condExpected(cc, f));
      checkVal("B target", brUpd.target, relTarget(pc, off));
      checkBit("B isBr", brUpd.isBr, 1'b0);
      driveBranch({`OP_BR, cc, 1'b0, r, 4'h0}, pc, f, 1'b0, 16'h0000);
      checkBit("BR actualTaken", brUpd.actualTaken, condExpected(cc, f));
      checkVal("BR target", brUpd.target, shadow[r]);  // Register target
      checkBit("BR isBr", brUpd.isBr, 1'b1);
    end
  endtask

  task automatic testPredictor();
    logic [8:0] off;
    word        pc, tgt;
    condCode    cc;
    off = 9'($urandom);
    pc  = word'($urandom);
    tgt = relTarget(pc, off);
    for (int a = 0; a < 2; a++) begin
      for (int p = 0; p < 2; p++) begin
        cc = a[0] ? `CC_UN : `CC_EQ;  // EQ with Z clear never taken
        driveBranch({`OP_B, cc, off}, pc, 3'b000, p[0], tgt);
        checkBit($sformatf("updatePc a%0d p%0d", a, p), brUpd.updatePc, a != p);
        checkBit($sformatf("wenBtb a%0d p%0d", a, p), brUpd.wenBtb, a[0]);
        checkBit($sformatf("wenBht a%0d p%0d", a, p), brUpd.wenBht, 1'b1);
      end
    end
    driveBranch({`OP_B, `CC_UN, off}, pc, 3'b000, 1'b1, tgt ^ 16'h0002);
    checkBit("updatePc wrong target", brUpd.updatePc, 1'b1);
    driveBranch({`OP_ADD, 12'h123}, pc, 3'b000, 1'b1, tgt);  // Not a branch
    checkBit("updatePc non-branch", brUpd.updatePc, 1'b0);
    checkBit("wenBtb non-branch", brUpd.wenBtb, 1'b0);
    checkBit("wenBht non-branch", brUpd.wenBht, 1'b0);
  endtask

  //////////////////////////////
  // Sequence
  //////////////////////////////
  initial begin
    void'($urandom(32'h4e4ae938));
    rst             = 1'b1;
    inst            = '0;  // ADD r0, r0, r0 during reset
    pcNext          = '0;
    flags           = '0;
    predictedTaken  = 1'b0;
    predictedTarget = '0;
    wbReq           = '0;
    for (int r = 0; r < 16; r++) begin
      shadow[r] = '0;
    end
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    testResetZero();
    testRegWrites();
    testDecodeTable();
    testImmediates();
    testBranches();
    testPredictor();
    @(posedge clk);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* decodeStage.f */
+incdir+logic
logic/decodePkg.sv
logic/registerFile.sv
logic/controlUnit.sv
logic/branchControl.sv
logic/decodeStage.sv
dv/decodeStage_asserts.sv
dv/decodeStage_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f decodeStage.f \
  --top-module decodeStage_tb -o simv
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/simv > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q "^PASS: all tests$" sim.log; then
  exit 0
fi
exit 1
